/* design/core_pkg.sv */
/*
  core package
  opcodes, ALU operations, halt codes, AXI4-Lite read channel
  structs and the payloads carried between pipeline stages
*/
`default_nettype none

package core_pkg;

  // 32-bit architectural word
  typedef logic [31:0] word_t;

  localparam word_t reset_pc = 32'h0000_0000;

  // major opcodes
  localparam logic [6:0] op_reg  = 7'b0110011;
  localparam logic [6:0] op_imm  = 7'b0010011;
  localparam logic [6:0] op_lui  = 7'b0110111;
  localparam logic [6:0] op_trap = 7'h6b;

  localparam logic [7:0] halt_fetch_error = 8'hff;

  localparam logic [1:0] resp_okay = 2'b00;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_t;

  typedef struct packed {
    word_t      addr;
    logic [2:0] prot;
  } axi_ar_t;

  typedef struct packed {
    word_t      data;
    logic [1:0] resp;
  } axi_r_t;

  typedef struct packed {
    word_t pc;
    word_t inst;
  } fetch_payload_t;

  typedef struct packed {
    word_t      pc;
    word_t      inst;
    alu_op_t    alu_op;
    word_t      op_a;
    word_t      op_b;
    logic [4:0] rd;
    logic       writes_rd;
    logic       is_trap;
    logic       fetch_error;
  } decode_payload_t;

  // record of the instruction leaving execute
  typedef struct packed {
    fetch_payload_t fetch;
    logic [4:0]     rd;
    word_t          data;
  } retire_info_t;

endpackage

`default_nettype wire

/* design/pipe_reg.sv */
/*
  pipeline register
  holds one stage payload of any packed type, loaded on demand
*/
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  wire      clock,
  input  wire      reset,
  input  wire      load,
  input  payload_t data_in,
  output payload_t data_out
);

  // payload held until the next load
  always_ff @(posedge clock) begin
    if (reset) begin
      data_out <= '0;
    end else if (load) begin
      data_out <= data_in;
    end
  end

endmodule

`default_nettype wire

/* design/register_file.sv */
/*
  register file
  32 registers, two read ports and one write-through write port,
  x0 reads as zero
*/
`timescale 1ns/1ps
`default_nettype none

module register_file #(
  parameter int data_width = 32
) (
  input  wire                   clock,
  input  wire                   reset,
  input  wire  [4:0]            rs1_addr,
  input  wire  [4:0]            rs2_addr,
  input  wire                   wr_enable,
  input  wire  [4:0]            wr_addr,
  input  wire  [data_width-1:0] wr_data,
  output logic [data_width-1:0] rs1_data,
  output logic [data_width-1:0] rs2_data
);

  logic [data_width-1:0] regs [1:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_enable && wr_addr != 5'd0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // same-cycle write is seen by decode
  always_comb begin
    if (rs1_addr == 5'd0) begin
      rs1_data = '0;
    end else if (wr_enable && wr_addr == rs1_addr) begin
      rs1_data = wr_data;
    end else begin
      rs1_data = regs[rs1_addr];
    end
    if (rs2_addr == 5'd0) begin
      rs2_data = '0;
    end else if (wr_enable && wr_addr == rs2_addr) begin
      rs2_data = wr_data;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

`default_nettype wire

/* design/pipe_control.sv */
/*
  pipeline control
  owns the decode and execute valid bits, the load enables
  and the halted state of the core
*/
`timescale 1ns/1ps
`default_nettype none

module pipe_control (
  input  wire  clock,
  input  wire  reset,
  input  wire  fetch_done,
  input  wire  halt_request,
  output logic fetch_load,
  output logic decode_valid,
  output logic exec_valid,
  output logic exec_load,
  output logic halted
);

  logic halt_take;

  // a second halt is ignored once stopped
  assign halt_take = halt_request && !halted;

  // execute finishes in one cycle, so decode drains every cycle;
  // no new instruction is taken while a halt is pending or done
  assign fetch_load = !halted && !halt_request;
  assign exec_load  = decode_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      decode_valid <= 1'b0;
      exec_valid   <= 1'b0;
      halted       <= 1'b0;
    end else begin
      decode_valid <= fetch_done && !halt_take;
      // younger instruction in decode is discarded on halt
      exec_valid   <= exec_load && !halt_take && !halted;
      if (halt_take) begin
        halted <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
/*
  instruction fetch
  pc register and AXI4-Lite address and data sequencing,
  one read outstanding at a time
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       fetch_load,
  input  wire                       halted,
  output logic                      ar_valid,
  input  wire                       ar_ready,
  output core_pkg::axi_ar_t         ar,
  input  wire                       r_valid,
  output logic                      r_ready,
  input  core_pkg::axi_r_t          r,
  output logic                      fetch_done,
  output core_pkg::fetch_payload_t  fetch_out,
  output logic                      fetch_error
);

  // unprivileged, secure, instruction access
  localparam logic [2:0] inst_prot = 3'b100;

  core_pkg::word_t pc;
  logic waiting;
  logic r_fire;

  // after halt the outstanding data is still taken, then dropped
  assign r_ready    = waiting && (fetch_load || halted);
  assign r_fire     = r_valid && r_ready;
  assign fetch_done = r_fire && !halted;

  // pc only moves after data, so the address holds under back-pressure
  assign ar.addr = pc;
  assign ar.prot = inst_prot;

  assign fetch_out.pc   = pc;
  assign fetch_out.inst = r.data;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc          <= core_pkg::reset_pc;
      ar_valid    <= 1'b0;
      waiting     <= 1'b0;
      fetch_error <= 1'b0;
    end else begin
      if (ar_valid) begin
        if (ar_ready) begin
          ar_valid <= 1'b0;
          waiting  <= 1'b1;
        end
      end else if (!waiting) begin
        // idle after reset
        ar_valid <= !halted;
      end else if (r_fire) begin
        waiting  <= 1'b0;
        ar_valid <= !halted;
      end

      if (fetch_done) begin
        pc          <= pc + 32'd4;
        fetch_error <= (r.resp != core_pkg::resp_okay);
      end
    end
  end

endmodule

`default_nettype wire

/* design/decode_unit.sv */
/*
  decode
  splits instruction fields, builds immediates, picks the ALU
  operation and operands from the register file read ports
*/
`timescale 1ns/1ps
`default_nettype none

module decode_unit #(
  parameter int data_width = 32
) (
  input  core_pkg::fetch_payload_t   fetch_in,
  output logic [4:0]                 rs1_addr,
  output logic [4:0]                 rs2_addr,
  input  wire  [data_width-1:0]      rs1_data,
  input  wire  [data_width-1:0]      rs2_data,
  output core_pkg::decode_payload_t  decode_out
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  core_pkg::word_t i_imm;
  core_pkg::word_t u_imm;

  assign opcode = fetch_in.inst[6:0];
  assign funct3 = fetch_in.inst[14:12];
  assign funct7 = fetch_in.inst[31:25];
  assign i_imm  = {{20{fetch_in.inst[31]}}, fetch_in.inst[31:20]};
  assign u_imm  = {fetch_in.inst[31:12], 12'h000};

  // trap reports x10, so it is read through rs1
  assign rs1_addr = (opcode == core_pkg::op_trap) ? 5'd10 : fetch_in.inst[19:15];
  assign rs2_addr = fetch_in.inst[24:20];

  always_comb begin
    decode_out = '0;
    decode_out.pc     = fetch_in.pc;
    decode_out.inst   = fetch_in.inst;
    decode_out.rd     = fetch_in.inst[11:7];
    decode_out.op_a   = rs1_data;
    decode_out.op_b   = rs2_data;
    decode_out.alu_op = core_pkg::alu_add;
    case (opcode)
      core_pkg::op_reg: begin
        decode_out.writes_rd = 1'b1;
        case (funct3)
          3'b000: decode_out.alu_op = funct7[5] ? core_pkg::alu_sub : core_pkg::alu_add;
          3'b010: decode_out.alu_op = core_pkg::alu_slt;
          3'b100: decode_out.alu_op = core_pkg::alu_xor;
          3'b110: decode_out.alu_op = core_pkg::alu_or;
          3'b111: decode_out.alu_op = core_pkg::alu_and;
          default: decode_out.writes_rd = 1'b0;
        endcase
        // only sub may set a funct7 bit
        if (funct7 != 7'b0000000 && !(funct3 == 3'b000 && funct7 == 7'b0100000)) begin
          decode_out.writes_rd = 1'b0;
        end
      end
      core_pkg::op_imm: begin
        decode_out.op_b      = i_imm;
        decode_out.writes_rd = 1'b1;
        case (funct3)
          3'b000: decode_out.alu_op = core_pkg::alu_add;
          3'b100: decode_out.alu_op = core_pkg::alu_xor;
          3'b110: decode_out.alu_op = core_pkg::alu_or;
          3'b111: decode_out.alu_op = core_pkg::alu_and;
          default: decode_out.writes_rd = 1'b0;
        endcase
      end
      core_pkg::op_lui: begin
        decode_out.op_b      = u_imm;
        decode_out.alu_op    = core_pkg::alu_pass_b;
        decode_out.writes_rd = 1'b1;
      end
      core_pkg::op_trap: begin
        decode_out.is_trap = 1'b1;
      end
      // unsupported opcodes retire with no write
      default: decode_out.writes_rd = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* design/exec_unit.sv */
/*
  execute
  ALU, register write request and halt detection
  for the instruction leaving the pipeline
*/
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
  parameter int data_width = 32
) (
  input  core_pkg::decode_payload_t decode_in,
  input  wire                       exec_valid,
  output logic                      wr_enable,
  output logic [4:0]                wr_addr,
  output logic [data_width-1:0]     wr_data,
  output core_pkg::retire_info_t    retire_info,
  output logic                      halt_request,
  output logic [7:0]                halt_code
);

  core_pkg::word_t result;

  always_comb begin
    case (decode_in.alu_op)
      core_pkg::alu_add:    result = decode_in.op_a + decode_in.op_b;
      core_pkg::alu_sub:    result = decode_in.op_a - decode_in.op_b;
      core_pkg::alu_and:    result = decode_in.op_a & decode_in.op_b;
      core_pkg::alu_or:     result = decode_in.op_a | decode_in.op_b;
      core_pkg::alu_xor:    result = decode_in.op_a ^ decode_in.op_b;
      core_pkg::alu_slt:    result = {31'd0, $signed(decode_in.op_a) < $signed(decode_in.op_b)};
      core_pkg::alu_pass_b: result = decode_in.op_b;
      default:              result = '0;
    endcase
  end

  // a faulting fetch never writes, nor does x0
  assign wr_enable = exec_valid && decode_in.writes_rd && !decode_in.fetch_error &&
                     (decode_in.rd != 5'd0);
  assign wr_addr   = decode_in.rd;
  assign wr_data   = result;

  assign retire_info.fetch.pc   = decode_in.pc;
  assign retire_info.fetch.inst = decode_in.inst;
  assign retire_info.rd         = wr_enable ? decode_in.rd : 5'd0;
  assign retire_info.data       = wr_enable ? result : '0;

  assign halt_request = exec_valid && (decode_in.is_trap || decode_in.fetch_error);
  // op_a holds x10 for a trap
  assign halt_code    = decode_in.fetch_error ? core_pkg::halt_fetch_error
                                              : decode_in.op_a[7:0];

endmodule

`default_nettype wire

/* design/retire_monitor.sv */
/*
  retire monitor
  registered retire record, trap code, and the cycle
  and retired instruction counters
*/
`timescale 1ns/1ps
`default_nettype none

module retire_monitor #(
  parameter int data_width = 32
) (
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    exec_valid,
  input  core_pkg::retire_info_t retire_info,
  input  wire                    halt_request,
  input  wire  [7:0]             halt_code,
  output logic                   retire_valid,
  output logic [data_width-1:0]  retire_pc,
  output logic [31:0]            retire_inst,
  output logic [4:0]             retire_rd,
  output logic [data_width-1:0]  retire_data,
  output logic [7:0]             trap_code,
  output logic [data_width-1:0]  cycle_count,
  output logic [data_width-1:0]  instr_count
);

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
      trap_code    <= 8'h00;
      cycle_count  <= '0;
      instr_count  <= '0;
    end else begin
      retire_valid <= exec_valid;
      cycle_count  <= cycle_count + 1'b1;
      // counts in step with retire_valid
      if (exec_valid) begin
        instr_count <= instr_count + 1'b1;
      end
      if (halt_request) begin
        trap_code <= halt_code;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (exec_valid) begin
      retire_pc   <= retire_info.fetch.pc;
      retire_inst <= retire_info.fetch.inst;
      retire_rd   <= retire_info.rd;
      retire_data <= retire_info.data;
    end
  end

endmodule

`default_nettype wire

/* design/core_top.sv */
/*
  core top level
  three-stage integer pipeline fetching over an AXI4-Lite read port,
  with a registered retire port and cycle and instruction counters
*/
`timescale 1ns/1ps
`default_nettype none

module core_top #(
  parameter int data_width = 32
) (
  input  wire                       clock,
  input  wire                       reset,
  output logic                      ar_valid,
  input  wire                       ar_ready,
  output core_pkg::axi_ar_t         ar,
  input  wire                       r_valid,
  output logic                      r_ready,
  input  core_pkg::axi_r_t          r,
  output logic                      retire_valid,
  output logic [data_width-1:0]     retire_pc,
  output logic [31:0]               retire_inst,
  output logic [4:0]                retire_rd,
  output logic [data_width-1:0]     retire_data,
  output logic                      halted,
  output logic [7:0]                trap_code,
  output logic [data_width-1:0]     cycle_count,
  output logic [data_width-1:0]     instr_count
);

  logic fetch_load;
  logic fetch_done;
  logic fetch_error;
  logic decode_valid;
  logic exec_valid;
  logic exec_load;
  logic halt_request;
  logic [7:0] halt_code;

  core_pkg::fetch_payload_t  fetch_out;
  core_pkg::fetch_payload_t  decode_in;
  core_pkg::decode_payload_t decode_out;
  core_pkg::decode_payload_t decode_tagged;
  core_pkg::decode_payload_t exec_in;
  core_pkg::retire_info_t    retire_info;

  logic [4:0] rs1_addr;
  logic [4:0] rs2_addr;
  logic [data_width-1:0] rs1_data;
  logic [data_width-1:0] rs2_data;
  logic wr_enable;
  logic [4:0] wr_addr;
  logic [data_width-1:0] wr_data;

  pipe_control pipe_control_inst (
    .clock        (clock),
    .reset        (reset),
    .fetch_done   (fetch_done),
    .halt_request (halt_request),
    .fetch_load   (fetch_load),
    .decode_valid (decode_valid),
    .exec_valid   (exec_valid),
    .exec_load    (exec_load),
    .halted       (halted)
  );

  fetch_unit fetch_unit_inst (
    .clock       (clock),
    .reset       (reset),
    .fetch_load  (fetch_load),
    .halted      (halted),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .ar          (ar),
    .r_valid     (r_valid),
    .r_ready     (r_ready),
    .r           (r),
    .fetch_done  (fetch_done),
    .fetch_out   (fetch_out),
    .fetch_error (fetch_error)
  );

  pipe_reg #(.payload_t(core_pkg::fetch_payload_t)) fetch_to_decode (
    .clock    (clock),
    .reset    (reset),
    .load     (fetch_done),
    .data_in  (fetch_out),
    .data_out (decode_in)
  );

  decode_unit #(.data_width(data_width)) decode_unit_inst (
    .fetch_in   (decode_in),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .decode_out (decode_out)
  );

  // error flag of the fetch travels beside the decode stage contents
  always_comb begin
    decode_tagged = decode_out;
    decode_tagged.fetch_error = fetch_error;
  end

  pipe_reg #(.payload_t(core_pkg::decode_payload_t)) decode_to_exec (
    .clock    (clock),
    .reset    (reset),
    .load     (exec_load),
    .data_in  (decode_tagged),
    .data_out (exec_in)
  );

  exec_unit #(.data_width(data_width)) exec_unit_inst (
    .decode_in    (exec_in),
    .exec_valid   (exec_valid),
    .wr_enable    (wr_enable),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .retire_info  (retire_info),
    .halt_request (halt_request),
    .halt_code    (halt_code)
  );

  register_file #(.data_width(data_width)) register_file_inst (
    .clock     (clock),
    .reset     (reset),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .wr_enable (wr_enable),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

  retire_monitor #(.data_width(data_width)) retire_monitor_inst (
    .clock        (clock),
    .reset        (reset),
    .exec_valid   (exec_valid),
    .retire_info  (retire_info),
    .halt_request (halt_request),
    .halt_code    (halt_code),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_inst  (retire_inst),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .trap_code    (trap_code),
    .cycle_count  (cycle_count),
    .instr_count  (instr_count)
  );

endmodule

`default_nettype wire

/* testbench/core_tb_sva.sv */
/*
  core assertions
  AXI4-Lite read address stability, one read outstanding,
  and a quiet retire port once the core has halted
*/
`timescale 1ns/1ps
`default_nettype none

module core_tb_sva (
  input wire                     clock,
  input wire                     reset,
  input wire                     ar_valid,
  input wire                     ar_ready,
  input wire core_pkg::axi_ar_t  ar,
  input wire                     r_valid,
  input wire                     r_ready,
  input wire                     retire_valid,
  input wire                     halted
);

  // address accepted and data not yet taken
  logic data_pending;
  int failure_count = 0;

  always_ff @(posedge clock) begin
    if (reset) begin
      data_pending <= 1'b0;
    end else if (ar_valid && ar_ready) begin
      data_pending <= 1'b1;
    end else if (r_valid && r_ready) begin
      data_pending <= 1'b0;
    end
  end

  ar_held: assert property (@(posedge clock) disable iff (reset)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else begin
      $error("ar_valid dropped or ar changed before ar_ready");
      failure_count++;
    end

  one_outstanding: assert property (@(posedge clock) disable iff (reset)
    data_pending |-> !ar_valid)
    else begin
      $error("new read address issued while read data is still pending");
      failure_count++;
    end

  no_retire_after_halt: assert property (@(posedge clock) disable iff (reset)
    halted && $past(halted) |-> !retire_valid)
    else begin
      $error("instruction retired after the core halted");
      failure_count++;
    end

  halt_sticks: assert property (@(posedge clock) disable iff (reset)
    halted |=> halted)
    else begin
      $error("halted dropped without reset");
      failure_count++;
    end

endmodule

bind core_top core_tb_sva core_tb_sva_inst (
  .clock        (clock),
  .reset        (reset),
  .ar_valid     (ar_valid),
  .ar_ready     (ar_ready),
  .ar           (ar),
  .r_valid      (r_valid),
  .r_ready      (r_ready),
  .retire_valid (retire_valid),
  .halted       (halted)
);

`default_nettype wire

/* testbench/core_tb.sv */
/*
  core testbench
  AXI4-Lite program memory with random latency, a reference model
  stepped in retire order, directed program tests and a watchdog
*/
`timescale 1ns/1ps
`default_nettype none

module core_tb;

  localparam int clock_period = 100;
  localparam int total_instructions = 44;
  localparam int max_fetch_cycles = 12;
  localparam int margin_cycles = 300;

  localparam logic [6:0] opc_reg  = 7'b0110011;
  localparam logic [6:0] opc_imm  = 7'b0010011;
  localparam logic [6:0] opc_lui  = 7'b0110111;
  localparam logic [6:0] opc_trap = 7'h6b;

  logic clock;
  logic reset;
  logic ar_valid;
  logic ar_ready;
  core_pkg::axi_ar_t ar;
  logic r_valid;
  logic r_ready;
  core_pkg::axi_r_t r;
  logic retire_valid;
  logic [31:0] retire_pc;
  logic [31:0] retire_inst;
  logic [4:0] retire_rd;
  logic [31:0] retire_data;
  logic halted;
  logic [7:0] trap_code;
  logic [31:0] cycle_count;
  logic [31:0] instr_count;

  logic [31:0] program_mem [0:63];
  logic [31:0] ref_regs [0:31];
  int prog_len;
  logic fault_enable;
  logic [31:0] fault_addr;
  logic [31:0] rng_state = 32'ha869a4ef;

  // memory model state
  logic busy;
  int ar_wait;
  int r_wait;
  logic [31:0] read_addr;

  string test_name;
  int error_count;
  int check_count;
  int test_count;

  core_top #(.data_width(32)) core_top_inst (
    .clock        (clock),
    .reset        (reset),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .ar           (ar),
    .r_valid      (r_valid),
    .r_ready      (r_ready),
    .r            (r),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_inst  (retire_inst),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted),
    .trap_code    (trap_code),
    .cycle_count  (cycle_count),
    .instr_count  (instr_count)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // 0 to 3 extra cycles
  function automatic int random_latency();
    return int'((next_random() >> 16) % 4);
  endfunction

  function automatic logic [31:0] reg_inst(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opc_reg};
  endfunction

  function automatic logic [31:0] imm_inst(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc_imm};
  endfunction

  function automatic logic [31:0] lui_inst(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, opc_lui};
  endfunction

  // AXI4-Lite read-only memory with random ready and data delays
  always @(posedge clock) begin
    if (reset) begin
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
      busy      = 1'b0;
      ar_wait   = 0;
      r_wait    = 0;
    end else begin
      if (r_valid && r_ready) begin
        r_valid <= 1'b0;
        busy     = 1'b0;
      end
      if (ar_valid && ar_ready) begin
        ar_ready <= 1'b0;
        read_addr = ar.addr;
        r_wait    = random_latency();
        busy      = 1'b1;
      end else if (ar_valid) begin
        if (ar_wait == 0) begin
          ar_ready <= 1'b1;
          ar_wait   = random_latency();
        end else begin
          ar_wait--;
        end
      end
      if (busy && !r_valid) begin
        if (r_wait == 0) begin
          r_valid <= 1'b1;
          r.data  <= ((read_addr >> 2) < 64) ? program_mem[read_addr >> 2] : 32'h0;
          // slave error for the faulting address
          r.resp  <= (fault_enable && read_addr == fault_addr) ? 2'b10 : 2'b00;
        end else begin
          r_wait--;
        end
      end
    end
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
      $display("Error in %s: %s expected %h, actual %h", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic clear_program();
    for (int i = 0; i < 64; i++) begin
      program_mem[i] = 32'h0;
    end
    prog_len = 0;
    fault_enable = 1'b0;
    fault_addr = 32'h0;
  endtask

  task automatic append_inst(input logic [31:0] inst);
    program_mem[prog_len] = inst;
    prog_len++;
  endtask

  task automatic reset_core();
    @(posedge clock);
    reset <= 1'b1;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
  endtask

  // reference execution of one instruction
  task automatic model_execute(input logic [31:0] inst, output logic [4:0] rd,
                               output logic [31:0] data, output logic is_trap);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic writes;
    a = ref_regs[inst[19:15]];
    b = ref_regs[inst[24:20]];
    imm = {{20{inst[31]}}, inst[31:20]};
    res = 32'h0;
    writes = 1'b1;
    is_trap = 1'b0;
    case (inst[6:0])
      opc_reg: begin
        case ({inst[31:25], inst[14:12]})
          {7'h00, 3'd0}: res = a + b;
          {7'h20, 3'd0}: res = a - b;
          {7'h00, 3'd2}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          {7'h00, 3'd4}: res = a ^ b;
          {7'h00, 3'd6}: res = a | b;
          {7'h00, 3'd7}: res = a & b;
          default: writes = 1'b0;
        endcase
      end
      opc_imm: begin
        case (inst[14:12])
          3'd0: res = a + imm;
          3'd4: res = a ^ imm;
          3'd6: res = a | imm;
          3'd7: res = a & imm;
          default: writes = 1'b0;
        endcase
      end
      opc_lui: res = {inst[31:12], 12'h000};
      opc_trap: begin
        is_trap = 1'b1;
        writes = 1'b0;
      end
      default: writes = 1'b0;
    endcase
    rd = (writes && inst[11:7] != 5'd0) ? inst[11:7] : 5'd0;
    data = (rd != 5'd0) ? res : 32'h0;
    if (rd != 5'd0) begin
      ref_regs[rd] = res;
    end
  endtask

  // reset, then follow retires until halt and a few cycles beyond
  task automatic run_program(input string name);
    logic [31:0] expected_pc;
    logic [31:0] exp_cycle;
    logic [31:0] exp_data;
    logic [4:0] exp_rd;
    logic [7:0] exp_code;
    logic is_trap;
    logic model_halted;
    int retired;
    int errors_before;
    int sva_before;
    test_name = name;
    errors_before = error_count;
    sva_before = core_top_inst.core_tb_sva_inst.failure_count;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = 32'h0;
    end
    expected_pc = 32'h0;
    exp_code = 8'h00;
    model_halted = 1'b0;
    retired = 0;
    reset_core();
    @(negedge clock);
    exp_cycle = 32'd0;
    check_value("cycle_count after reset", exp_cycle, cycle_count);
    check_value("instr_count after reset", 32'd0, instr_count);
    check_value("ar_valid r_ready retire_valid halted after reset", 32'd0,
                {28'd0, ar_valid, r_ready, retire_valid, halted});
    while (!halted) begin
      @(negedge clock);
      exp_cycle += 32'd1;
      check_value("cycle_count step", exp_cycle, cycle_count);
      if (retire_valid) begin
        retired++;
        assert (!model_halted) else begin
          $display("test %s: retire seen after the halting instruction", name);
          error_count++;
        end
        check_value("retire_pc", expected_pc, retire_pc);
        check_value("retire_inst", program_mem[expected_pc >> 2], retire_inst);
        if (fault_enable && expected_pc == fault_addr) begin
          exp_rd = 5'd0;
          exp_data = 32'h0;
          exp_code = 8'hff;
          model_halted = 1'b1;
        end else begin
          model_execute(program_mem[expected_pc >> 2], exp_rd, exp_data, is_trap);
          if (is_trap) begin
            exp_code = ref_regs[10][7:0];
            model_halted = 1'b1;
          end
        end
        check_value("retire_rd", {27'd0, exp_rd}, {27'd0, retire_rd});
        check_value("retire_data", exp_data, retire_data);
        expected_pc += 32'd4;
      end
    end
    assert (model_halted) else begin
      $display("test %s: core halted before the halting instruction retired", name);
      error_count++;
    end
    check_value("trap_code", {24'd0, exp_code}, {24'd0, trap_code});
    check_value("instr_count at halt", retired, instr_count);
    repeat (8) begin
      @(negedge clock);
      exp_cycle += 32'd1;
      check_value("cycle_count step after halt", exp_cycle, cycle_count);
      assert (!retire_valid && halted) else begin
        $display("test %s: retire or loss of halted after the core stopped", name);
        error_count++;
      end
    end
    error_count += core_top_inst.core_tb_sva_inst.failure_count - sva_before;
    test_count++;
    if (error_count == errors_before) begin
      $display("test %s: ok, %0d instructions retired", name, retired);
    end else begin
      $display("test %s: %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic alu_operations();
    clear_program();
    append_inst(imm_inst(3'd0, 5'd1, 5'd0, 12'd100));
    append_inst(imm_inst(3'd0, 5'd2, 5'd0, 12'hff9));
    append_inst(reg_inst(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
    append_inst(reg_inst(7'h20, 3'd0, 5'd4, 5'd1, 5'd2));
    append_inst(reg_inst(7'h00, 3'd7, 5'd5, 5'd1, 5'd2));
    append_inst(reg_inst(7'h00, 3'd6, 5'd6, 5'd1, 5'd2));
    append_inst(reg_inst(7'h00, 3'd4, 5'd7, 5'd1, 5'd2));
    append_inst(reg_inst(7'h00, 3'd2, 5'd8, 5'd2, 5'd1));
    append_inst(reg_inst(7'h00, 3'd2, 5'd9, 5'd1, 5'd2));
    append_inst(imm_inst(3'd7, 5'd11, 5'd1, 12'h0f0));
    append_inst(imm_inst(3'd4, 5'd12, 5'd2, 12'hfff));
    append_inst(imm_inst(3'd6, 5'd13, 5'd1, 12'h700));
    append_inst(reg_inst(7'h20, 3'd0, 5'd10, 5'd4, 5'd12));
    append_inst({25'd0, opc_trap});
    run_program("alu_operations");
  endtask

  // each instruction reads the result of the one before
  task automatic dependency_chain();
    clear_program();
    append_inst(imm_inst(3'd0, 5'd1, 5'd0, 12'd1));
    repeat (5) append_inst(reg_inst(7'h00, 3'd0, 5'd1, 5'd1, 5'd1));
    append_inst(imm_inst(3'd0, 5'd2, 5'd1, 12'hffd));
    append_inst(reg_inst(7'h00, 3'd4, 5'd3, 5'd2, 5'd1));
    append_inst(reg_inst(7'h00, 3'd0, 5'd10, 5'd3, 5'd2));
    append_inst({25'd0, opc_trap});
    run_program("dependency_chain");
  endtask

  task automatic zero_register();
    clear_program();
    append_inst(imm_inst(3'd0, 5'd0, 5'd0, 12'd55));
    append_inst(lui_inst(5'd1, 20'h12345));
    append_inst(reg_inst(7'h00, 3'd0, 5'd2, 5'd0, 5'd1));
    append_inst(lui_inst(5'd0, 20'habcde));
    append_inst(reg_inst(7'h00, 3'd6, 5'd3, 5'd0, 5'd0));
    // unsupported load opcode
    append_inst(32'h0000_2083);
    append_inst(imm_inst(3'd0, 5'd4, 5'd1, 12'd0));
    append_inst(imm_inst(3'd4, 5'd10, 5'd4, 12'h05a));
    append_inst({25'd0, opc_trap});
    run_program("zero_register");
  endtask

  task automatic trap_halt();
    clear_program();
    append_inst(imm_inst(3'd0, 5'd10, 5'd0, 12'h1a5));
    append_inst(imm_inst(3'd0, 5'd5, 5'd10, 12'd1));
    append_inst({25'd0, opc_trap});
    // never retire
    append_inst(imm_inst(3'd0, 5'd6, 5'd0, 12'd1));
    append_inst(imm_inst(3'd0, 5'd7, 5'd0, 12'd2));
    append_inst({25'd0, opc_trap});
    run_program("trap_halt");
  endtask

  task automatic fetch_error_halt();
    clear_program();
    append_inst(imm_inst(3'd0, 5'd1, 5'd0, 12'd3));
    append_inst(imm_inst(3'd0, 5'd2, 5'd1, 12'd4));
    append_inst(imm_inst(3'd0, 5'd3, 5'd0, 12'd9));
    append_inst(imm_inst(3'd0, 5'd10, 5'd0, 12'd7));
    append_inst({25'd0, opc_trap});
    fault_enable = 1'b1;
    fault_addr = 32'h8;
    run_program("fetch_error_halt");
  endtask

  initial begin
    #(longint'(total_instructions * max_fetch_cycles + margin_cycles) * clock_period);
    $display("watchdog expired before all tests finished");
    $display("Testbench failed");
    $finish;
  end

  initial begin
    reset = 1'b1;
    ar_ready = 1'b0;
    r_valid = 1'b0;
    r = '0;
    error_count = 0;
    check_count = 0;
    test_count = 0;
    clear_program();
    alu_operations();
    dependency_chain();
    zero_register();
    trap_halt();
    fetch_error_halt();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
design/core_pkg.sv
design/pipe_reg.sv
design/register_file.sv
design/pipe_control.sv
design/fetch_unit.sv
design/decode_unit.sv
design/exec_unit.sv
design/retire_monitor.sv
design/core_top.sv
testbench/core_tb_sva.sv
testbench/core_tb.sv

/* Bender.yml */
package:
  name: core

sources:
  - design/core_pkg.sv
  - design/pipe_reg.sv
  - design/register_file.sv
  - design/pipe_control.sv
  - design/fetch_unit.sv
  - design/decode_unit.sv
  - design/exec_unit.sv
  - design/retire_monitor.sv
  - design/core_top.sv
  - target: test
    files:
      - testbench/core_tb_sva.sv
      - testbench/core_tb.sv
